// ==== sources.f ====
logic/wcache_pkg.sv
logic/write_buffer.sv
logic/write_channel_axi.sv
logic/wt_write_path.sv
test/axi_mem_model.sv
test/wt_write_path_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -j 0 --top-module wt_write_path_tb -Mdir obj_dir -f sources.f
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/Vwt_write_path_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Errors found" "$LOG"; then
   echo "FAIL"
   exit 1
fi
if [ $status -ne 0 ]; then
   echo "FAIL: simulator exited with status $status"
   exit 1
fi

echo "PASS"
exit 0

// ==== test/write_cases.txt ====
# word_addr(hex) data(hex) strobe(hex) error_responses(dec)
# byte address is word_addr*4, so word_addr bit 0 selects the upper half of the 64-bit beat
000 a0a1a2a3 f 0
001 b0b1b2b3 f 0
002 c0c1c2c3 3 0
003 d0d1d2d3 c 1
004 e0e1e2e3 1 0
005 f0f1f2f3 8 0
001 5566778a 6 2
000 0badcafe 9 0
010 12345678 f 0
011 9abcdef0 f 3
010 deadbeef 2 0
011 feedface 4 0
02a 01020304 f 0
02b 05060708 a 1
03f 89abcdef 5 0
07e 76543210 f 0
07f fedcba98 f 0
040 13579bdf 0 0
041 2468ace0 f 2
07e 0f0f0f0f 3 0
055 aaaa5555 f 0
054 5555aaaa e 1
020 c001d00d f 0
021 facefeed 7 0
020 11110000 c 0

// ==== test/wt_write_path_tb.sv ====
module wt_write_path_tb
   import wcache_pkg::*;
();

   localparam int                  WBUF_DEPTH      = 4;
   localparam int                  AXI_ID_W        = 2;
   localparam logic [AXI_ID_W-1:0] AXI_ID          = 2'b10;
   localparam int                  PERIOD          = 8;
   localparam int                  DRIVE_DLY       = 1;
   localparam int                  MEM_WORDS       = 64;
   localparam int                  CYCLES_PER_CASE = 200;

   logic                clk = 1'b0;
   logic                reset;
   logic                valid;
   fe_req_t             req;
   logic                ready;
   logic                drained;
   logic                awvalid;
   axi_aw_t             aw;
   logic [AXI_ID_W-1:0] awid;
   logic                awready;
   logic                wvalid;
   axi_w_t              w;
   logic                wready;
   logic                bvalid;
   axi_resp_e           bresp;
   logic                bready;
   logic [7:0]          cur_errs;

   logic [29:0] case_addr [$];
   logic [31:0] case_data [$];
   logic [3:0]  case_strb [$];
   int          case_errs [$];
   logic [63:0] ref_mem [MEM_WORDS];
   int          n_cases = 0;
   int          done_cnt = 0;
   int          attempts = 0;
   logic        saw_full = 1'b0;

   always #(PERIOD / 2) clk = ~clk;

   wt_write_path #(
      .WBUF_DEPTH (WBUF_DEPTH),
      .AXI_ID_W   (AXI_ID_W),
      .AXI_ID     (AXI_ID)
   ) i_wt_write_path (
      .clk (clk), .reset (reset), .valid (valid), .req (req), .ready (ready),
      .drained (drained), .awvalid (awvalid), .aw (aw), .awid (awid),
      .awready (awready), .wvalid (wvalid), .w (w), .wready (wready),
      .bvalid (bvalid), .bresp (bresp), .bready (bready)
   );

   axi_mem_model #(
      .MEM_WORDS (MEM_WORDS)
   ) i_mem (
      .clk (clk), .reset (reset), .err_count (cur_errs),
      .awvalid (awvalid), .awaddr (aw.awaddr), .awready (awready),
      .wvalid (wvalid), .wdata (w.wdata), .wstrb (w.wstrb), .wready (wready),
      .bvalid (bvalid), .bresp (bresp), .bready (bready)
   );

   task automatic fail_run(string why);
      $display("%s", why);
      $display("Errors found");
      $fatal(1);
   endtask

   task automatic check(string name, logic [63:0] expected, logic [63:0] got);
      if (expected !== got)
         fail_run($sformatf("Error %s expected %h got %h", name, expected, got));
   endtask

   task automatic load_cases();
      int          fd;
      int          n;
      string       line;
      logic [29:0] a;
      logic [31:0] d;
      logic [3:0]  s;
      int          e;
      fd = $fopen("test/write_cases.txt", "r");
      if (fd == 0)
         fail_run("cannot open test/write_cases.txt");
      while ($fgets(line, fd) != 0)
      begin
         if (line.len() < 2 || line[0] == "#")
            continue;
         n = $sscanf(line, "%h %h %h %d", a, d, s, e);
         if (n != 4)
            fail_run({"malformed line in case file: ", line});
         if (a >= 30'(2 * MEM_WORDS))
            fail_run({"case address outside the slave memory: ", line});
         case_addr.push_back(a);
         case_data.push_back(d);
         case_strb.push_back(s);
         case_errs.push_back(e);
      end
      $fclose(fd);
      if (case_addr.size() == 0)
         fail_run("case file holds no writes");
      n_cases = case_addr.size();
   endtask

   // AXI handshakes sampled mid-cycle and completed on the next rising edge
   always @(negedge clk)
   begin : monitor
      logic [31:0] byte_addr;
      logic [7:0]  exp_strb;
      if (!reset && done_cnt < n_cases)
      begin
         byte_addr = {case_addr[done_cnt], 2'b00};
         exp_strb  = byte_addr[2] ? {case_strb[done_cnt], 4'h0} : {4'h0, case_strb[done_cnt]};
         if (awvalid && awready)
         begin
            attempts++;
            check("awaddr", 64'({byte_addr[31:3], 3'b000}), 64'(aw.awaddr));
            check("awlen", 64'd0, 64'(aw.awlen));
            check("awsize", 64'd3, 64'(aw.awsize));
            check("awburst", 64'd0, 64'(aw.awburst));
            check("awlock", 64'd0, 64'(aw.awlock));
            check("awcache", 64'b0011, 64'(aw.awcache));
            check("awprot", 64'd0, 64'(aw.awprot));
            check("awqos", 64'd0, 64'(aw.awqos));
            check("awid", 64'(AXI_ID), 64'(awid));
         end
         if (wvalid && wready)
         begin
            check("wdata", {case_data[done_cnt], case_data[done_cnt]}, w.wdata);
            check("wstrb", 64'(exp_strb), 64'(w.wstrb));
            check("wlast", 64'd1, 64'(w.wlast));
         end
         if (bvalid && bready && bresp == OKAY)
         begin
            check("attempts", 64'(case_errs[done_cnt] + 1), 64'(attempts));
            for (int k = 0; k < 8; k++)
            begin
               if (exp_strb[k])
                  ref_mem[byte_addr[8:3]][k*8 +: 8] = case_data[done_cnt][(k%4)*8 +: 8];
            end
            attempts = 0;
            done_cnt++;
            cur_errs = (done_cnt < n_cases) ? 8'(case_errs[done_cnt]) : 8'd0;
         end
      end
   end

   initial
   begin
      logic got_accept;
      reset    = 1'b1;
      valid    = 1'b0;
      req      = '0;
      cur_errs = 8'd0;
      load_cases();
      cur_errs = 8'(case_errs[0]);
      repeat (16) @(posedge clk);
      for (int i = 0; i < MEM_WORDS; i++)
         ref_mem[i] = i_mem.mem[i];   // starting image of the slave memory
      #DRIVE_DLY reset = 1'b0;
      @(negedge clk);
      check("ready", 64'd1, 64'(ready));
      check("drained", 64'd1, 64'(drained));
      check("awvalid", 64'd0, 64'(awvalid));
      check("wvalid", 64'd0, 64'(wvalid));
      check("bready", 64'd0, 64'(bready));
      @(posedge clk);
      for (int i = 0; i < n_cases; i++)
      begin
         #DRIVE_DLY;
         valid     = 1'b1;
         req.addr  = case_addr[i];
         req.wdata = case_data[i];
         req.wstrb = case_strb[i];
         do
         begin
            @(negedge clk);
            got_accept = ready;
            if (!ready)
               saw_full = 1'b1;
            @(posedge clk);
         end
         while (!got_accept);
      end
      #DRIVE_DLY;
      valid = 1'b0;
      req   = '0;
      wait (done_cnt == n_cases);
      check("drained", 64'd0, 64'(drained));   // last response still in flight
      while (!drained)
         @(negedge clk);
      for (int i = 0; i < MEM_WORDS; i++)
         check($sformatf("mem[%0d]", i), ref_mem[i], i_mem.mem[i]);
      if (!saw_full)
         fail_run("front-end ready never dropped, the buffer was never filled");
      else
      begin
         $display("No errors");
         $finish;
      end
   end

   initial
   begin
      wait (n_cases > 0);
      repeat (16 + CYCLES_PER_CASE * n_cases) @(posedge clk);
      fail_run("timeout: the write path did not finish all cases in time");
   end

endmodule

// ==== test/axi_mem_model.sv ====
module axi_mem_model
   import wcache_pkg::*;
#(
   parameter int MEM_WORDS = 64
)
(
   input  logic        clk,
   input  logic        reset,
   input  logic [7:0]  err_count,   // error responses owed to the write in flight
   input  logic        awvalid,
   input  logic [31:0] awaddr,
   output logic        awready,
   input  logic        wvalid,
   input  logic [63:0] wdata,
   input  logic [7:0]  wstrb,
   output logic        wready,
   output logic        bvalid,
   output axi_resp_e   bresp,
   input  logic        bready
);

   localparam int IDX_W = $clog2(MEM_WORDS);

   logic [63:0]      mem [MEM_WORDS];
   integer           seed = 32'haed8abea;
   logic [2:0]       aw_wait;
   logic [2:0]       w_wait;
   logic [IDX_W-1:0] idx;
   logic [7:0]       errs_sent;

   initial
   begin
      for (int i = 0; i < MEM_WORDS; i++)
      begin
         mem[i] = {32'h0c0d_e000 ^ 32'(i), ~(32'h5a00_0000 + 32'(i))};
      end
   end

   always @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         awready   <= 1'b0;
         wready    <= 1'b0;
         bvalid    <= 1'b0;
         bresp     <= OKAY;
         aw_wait   <= 3'd0;
         w_wait    <= 3'd0;
         idx       <= '0;
         errs_sent <= 8'd0;
      end
      else
      begin
         if (awvalid && awready)
         begin
            awready <= 1'b0;
            idx     <= awaddr[IDX_W+2:3];
            aw_wait <= 3'($random(seed));   // stall before the next address
         end
         else if (awvalid)
         begin
            if (aw_wait == 3'd0)
               awready <= 1'b1;
            else
               aw_wait <= aw_wait - 3'd1;
         end

         if (wvalid && wready)
         begin
            wready <= 1'b0;
            w_wait <= 3'($random(seed));
            bvalid <= 1'b1;
            if (errs_sent < err_count)
            begin
               bresp     <= SLVERR;   // rejected and memory left untouched
               errs_sent <= errs_sent + 8'd1;
            end
            else
            begin
               bresp     <= OKAY;
               errs_sent <= 8'd0;
               for (int b = 0; b < 8; b++)
               begin
                  if (wstrb[b])
                     mem[idx][b*8 +: 8] <= wdata[b*8 +: 8];
               end
            end
         end
         else if (wvalid)
         begin
            if (w_wait == 3'd0)
               wready <= 1'b1;
            else
               w_wait <= w_wait - 3'd1;
         end

         if (bvalid && bready)
            bvalid <= 1'b0;
      end
   end

endmodule

// ==== logic/wt_write_path.sv ====
module wt_write_path
   import wcache_pkg::*;
#(
   parameter int                  WBUF_DEPTH = 4,
   parameter int                  AXI_ID_W   = 1,
   parameter logic [AXI_ID_W-1:0] AXI_ID     = '0
)
(
   input  logic                clk,
   input  logic                reset,

   // cache front end
   input  logic                valid,
   input  fe_req_t             req,
   output logic                ready,
   output logic                drained,

   // AXI4 write
   output logic                awvalid,
   output axi_aw_t             aw,
   output logic [AXI_ID_W-1:0] awid,
   input  logic                awready,
   output logic                wvalid,
   output axi_w_t              w,
   input  logic                wready,
   input  logic                bvalid,
   input  axi_resp_e           bresp,
   output logic                bready
);

   fe_req_t head_req;
   logic    pending;
   logic    full;
   logic    empty;
   logic    pop;
   logic    idle;

   assign ready   = !full;
   assign drained = empty && idle;   // nothing queued, nothing in flight

   write_buffer #(
      .WBUF_DEPTH (WBUF_DEPTH)
   ) i_write_buffer (
      .clk      (clk),
      .reset    (reset),
      .push     (valid),
      .push_req (req),
      .pop      (pop),
      .head_req (head_req),
      .pending  (pending),
      .full     (full),
      .empty    (empty)
   );

   write_channel_axi #(
      .AXI_ID_W (AXI_ID_W),
      .AXI_ID   (AXI_ID)
   ) i_write_channel_axi (
      .clk     (clk),
      .reset   (reset),
      .pending (pending),
      .req     (head_req),
      .pop     (pop),
      .idle    (idle),
      .awvalid (awvalid),
      .aw      (aw),
      .awid    (awid),
      .awready (awready),
      .wvalid  (wvalid),
      .w       (w),
      .wready  (wready),
      .bvalid  (bvalid),
      .bresp   (bresp),
      .bready  (bready)
   );

endmodule

// ==== logic/write_channel_axi.sv ====
module write_channel_axi
   import wcache_pkg::*;
#(
   parameter int                  AXI_ID_W = 1,
   parameter logic [AXI_ID_W-1:0] AXI_ID   = '0
)
(
   input  logic                clk,
   input  logic                reset,

   // buffer side
   input  logic                pending,
   input  fe_req_t             req,
   output logic                pop,
   output logic                idle,

   // address phase
   output logic                awvalid,
   output axi_aw_t             aw,
   output logic [AXI_ID_W-1:0] awid,
   input  logic                awready,

   // data phase
   output logic                wvalid,
   output axi_w_t              w,
   input  logic                wready,

   // response phase
   input  logic                bvalid,
   input  axi_resp_e           bresp,
   output logic                bready
);

   localparam int LANE_W = BE_BYTE_W - FE_BYTE_W;
   localparam int LANES  = BE_DATA_W / FE_DATA_W;

   wr_state_e         state;
   wr_state_e         state_nxt;
   logic              resp_ok;
   logic [LANE_W-1:0] lane;

   assign resp_ok  = bvalid && (bresp == OKAY);

   // address bit 2 picks the 32-bit half of the bus
   assign lane = req.addr[LANE_W-1:0];

   always_comb
   begin
      aw.awaddr  = {req.addr[FE_ADDR_W-FE_BYTE_W-1:LANE_W], {BE_BYTE_W{1'b0}}};
      aw.awlen   = 8'd0;             // single beat
      aw.awsize  = 3'(BE_BYTE_W);    // full bus width
      aw.awburst = 2'd0;
      aw.awlock  = 1'b0;
      aw.awcache = 4'b0011;
      aw.awprot  = 3'd0;
      aw.awqos   = 4'd0;
   end

   assign awid = AXI_ID;

   always_comb
   begin
      w.wdata = {LANES{req.wdata}};   // word copied to every lane
      w.wstrb = BE_NBYTES'(req.wstrb) << (lane * FE_NBYTES);
      w.wlast = wvalid;
   end

   always_comb
   begin
      state_nxt = state;
      case (state)
         ST_IDLE:
         begin
            if (pending)
            begin
               state_nxt = ST_ADDRESS;
            end
         end
         ST_ADDRESS:
         begin
            if (!pending)
            begin
               state_nxt = ST_IDLE;   // last entry was just popped
            end
            else if (awready)
            begin
               state_nxt = ST_WRITE;
            end
         end
         ST_WRITE:
         begin
            if (wready)
            begin
               state_nxt = ST_VERIFY;
            end
         end
         ST_VERIFY:
         begin
            // next head after OKAY or same entry after an error
            if (bvalid)
            begin
               state_nxt = ST_ADDRESS;
            end
         end
         default:
         begin
            state_nxt = ST_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state <= ST_IDLE;
      end
      else
      begin
         state <= state_nxt;
      end
   end

   // pending cannot fall while in ST_ADDRESS with an entry, so awvalid holds until accepted
   assign awvalid = (state == ST_ADDRESS) && pending;
   assign wvalid  = (state == ST_WRITE);
   assign bready  = (state == ST_VERIFY);
   assign pop     = (state == ST_VERIFY) && resp_ok;
   assign idle    = (state == ST_IDLE);

endmodule

// ==== logic/write_buffer.sv ====
module write_buffer
   import wcache_pkg::*;
#(
   parameter int WBUF_DEPTH = 4
)
(
   input  logic    clk,
   input  logic    reset,

   input  logic    push,
   input  fe_req_t push_req,
   input  logic    pop,

   output fe_req_t head_req,
   output logic    pending,
   output logic    full,
   output logic    empty
);

   localparam int PTR_W = (WBUF_DEPTH > 1) ? $clog2(WBUF_DEPTH) : 1;
   localparam int CNT_W = $clog2(WBUF_DEPTH + 1);

   fe_req_t          mem [WBUF_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_push;
   logic             do_pop;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(WBUF_DEPTH - 1))
      begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   // front end only sees an accept while there is room
   assign do_push = push && !full;
   assign do_pop  = pop && !empty;

   assign empty   = (count == '0);
   assign full    = (count == CNT_W'(WBUF_DEPTH));
   assign pending = !empty;

   assign head_req = mem[rd_ptr];   // held until popped, so a retry resends the same entry

   always_ff @(posedge clk)
   begin
      if (do_push)
      begin
         mem[wr_ptr] <= push_req;
      end
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_push)
         begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (do_pop)
         begin
            rd_ptr <= next_ptr(rd_ptr);
         end

         // push and pop together leave the count alone
         case ({do_push, do_pop})
            2'b10:
            begin
               count <= count + 1'b1;
            end
            2'b01:
            begin
               count <= count - 1'b1;
            end
            default:
            begin
               count <= count;
            end
         endcase
      end
   end

endmodule

// ==== logic/wcache_pkg.sv ====
package wcache_pkg;

   // one 32-bit word per front-end request
   localparam int FE_ADDR_W = 32;
   localparam int FE_DATA_W = 32;
   localparam int FE_NBYTES = FE_DATA_W / 8;
   localparam int FE_BYTE_W = $clog2(FE_NBYTES);

   // 64-bit AXI data bus on the back end
   localparam int BE_DATA_W = 64;
   localparam int BE_NBYTES = BE_DATA_W / 8;
   localparam int BE_BYTE_W = $clog2(BE_NBYTES);

   typedef struct packed {
      logic [FE_ADDR_W-FE_BYTE_W-1:0] addr;   // word address
      logic [FE_DATA_W-1:0]           wdata;
      logic [FE_NBYTES-1:0]           wstrb;
   } fe_req_t;

   typedef struct packed {
      logic [FE_ADDR_W-1:0] awaddr;
      logic [7:0]           awlen;
      logic [2:0]           awsize;
      logic [1:0]           awburst;
      logic                 awlock;
      logic [3:0]           awcache;
      logic [2:0]           awprot;
      logic [3:0]           awqos;
   } axi_aw_t;

   typedef struct packed {
      logic [BE_DATA_W-1:0] wdata;
      logic [BE_NBYTES-1:0] wstrb;
      logic                 wlast;
   } axi_w_t;

   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      EXOKAY = 2'b01,
      SLVERR = 2'b10,
      DECERR = 2'b11
   } axi_resp_e;

   typedef enum logic [1:0] {
      ST_IDLE    = 2'd0,
      ST_ADDRESS = 2'd1,
      ST_WRITE   = 2'd2,
      ST_VERIFY  = 2'd3
   } wr_state_e;

endpackage
